//--- flist.f
source/bus_pkg.sv
source/read_arbiter.sv
source/write_channel.sv
source/mem_bridge_top.sv
test/axi_slave_model.sv
test/tb_mem_bridge.sv

//--- source/bus_pkg.sv
`default_nettype none

package bus_pkg;

    // Width of the AXI ID fields on every channel
    localparam int ID_WIDTH = 4;

    typedef logic [ID_WIDTH-1:0] axi_id_t;

    // Instruction fetches and data accesses travel under separate IDs
    localparam axi_id_t IC_ID = 4'd0;
    localparam axi_id_t DC_ID = 4'd1;

    // Read engine, one line in flight at a time
    typedef enum logic [1:0] {
        RD_IDLE = 2'd0,
        RD_ADDR = 2'd1,
        RD_DATA = 2'd2
    } rd_state_e;

    // Write engine, AW and W are issued together in WR_SEND
    typedef enum logic [1:0] {
        WR_IDLE = 2'd0,
        WR_SEND = 2'd1,
        WR_RESP = 2'd2
    } wr_state_e;

endpackage

`default_nettype wire

//--- source/mem_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bridge_top #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_WIDTH = 128
) (
    input  wire                        clk,
    input  wire                        arst_n_i,
    // Instruction cache read port
    input  wire                        ic_rd_req_i,
    input  wire [ADDR_WIDTH-1:0]       ic_rd_addr_i,
    output logic                       ic_rd_rdy_o,
    output logic                       ic_ret_valid_o,
    output logic [LINE_WIDTH-1:0]      ic_ret_data_o,
    // Data cache read port
    input  wire                        dc_rd_req_i,
    input  wire [ADDR_WIDTH-1:0]       dc_rd_addr_i,
    output logic                       dc_rd_rdy_o,
    output logic                       dc_ret_valid_o,
    output logic [LINE_WIDTH-1:0]      dc_ret_data_o,
    // Data cache write port
    input  wire                        dc_wr_req_i,
    input  wire [ADDR_WIDTH-1:0]       dc_wr_addr_i,
    input  wire [LINE_WIDTH/8-1:0]     dc_wr_strb_i,
    input  wire [LINE_WIDTH-1:0]       dc_wr_data_i,
    output logic                       dc_wr_rdy_o,
    // AR and R channels
    output bus_pkg::axi_id_t           ar_id_o,
    output logic [ADDR_WIDTH-1:0]      ar_addr_o,
    output logic                       ar_valid_o,
    input  wire                        ar_ready_i,
    input  wire bus_pkg::axi_id_t      r_id_i,
    input  wire [LINE_WIDTH-1:0]       r_data_i,
    input  wire                        r_valid_i,
    output logic                       r_ready_o,
    // AW, W and B channels
    output bus_pkg::axi_id_t           aw_id_o,
    output logic [ADDR_WIDTH-1:0]      aw_addr_o,
    output logic                       aw_valid_o,
    input  wire                        aw_ready_i,
    output logic [LINE_WIDTH-1:0]      w_data_o,
    output logic [LINE_WIDTH/8-1:0]    w_strb_o,
    output logic                       w_valid_o,
    input  wire                        w_ready_i,
    input  wire bus_pkg::axi_id_t      b_id_i,
    input  wire                        b_valid_i,
    output logic                       b_ready_o
);

    // Orders data reads behind an outstanding write
    logic wr_busy;

    read_arbiter #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) u_read_arbiter (
        .clk            (clk),
        .arst_n_i       (arst_n_i),
        .ic_rd_req_i    (ic_rd_req_i),
        .ic_rd_addr_i   (ic_rd_addr_i),
        .ic_rd_rdy_o    (ic_rd_rdy_o),
        .ic_ret_valid_o (ic_ret_valid_o),
        .ic_ret_data_o  (ic_ret_data_o),
        .dc_rd_req_i    (dc_rd_req_i),
        .dc_rd_addr_i   (dc_rd_addr_i),
        .dc_rd_rdy_o    (dc_rd_rdy_o),
        .dc_ret_valid_o (dc_ret_valid_o),
        .dc_ret_data_o  (dc_ret_data_o),
        .wr_busy_i      (wr_busy),
        .ar_id_o        (ar_id_o),
        .ar_addr_o      (ar_addr_o),
        .ar_valid_o     (ar_valid_o),
        .ar_ready_i     (ar_ready_i),
        .r_id_i         (r_id_i),
        .r_data_i       (r_data_i),
        .r_valid_i      (r_valid_i),
        .r_ready_o      (r_ready_o)
    );

    write_channel #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) u_write_channel (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .dc_wr_req_i  (dc_wr_req_i),
        .dc_wr_addr_i (dc_wr_addr_i),
        .dc_wr_strb_i (dc_wr_strb_i),
        .dc_wr_data_i (dc_wr_data_i),
        .dc_wr_rdy_o  (dc_wr_rdy_o),
        .wr_busy_o    (wr_busy),
        .aw_id_o      (aw_id_o),
        .aw_addr_o    (aw_addr_o),
        .aw_valid_o   (aw_valid_o),
        .aw_ready_i   (aw_ready_i),
        .w_data_o     (w_data_o),
        .w_strb_o     (w_strb_o),
        .w_valid_o    (w_valid_o),
        .w_ready_i    (w_ready_i),
        .b_id_i       (b_id_i),
        .b_valid_i    (b_valid_i),
        .b_ready_o    (b_ready_o)
    );

endmodule

`default_nettype wire

//--- source/read_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module read_arbiter #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_WIDTH = 128
) (
    input  wire                      clk,
    input  wire                      arst_n_i,
    // Instruction cache read port
    input  wire                      ic_rd_req_i,
    input  wire [ADDR_WIDTH-1:0]     ic_rd_addr_i,
    output logic                     ic_rd_rdy_o,
    output logic                     ic_ret_valid_o,
    output logic [LINE_WIDTH-1:0]    ic_ret_data_o,
    // Data cache read port
    input  wire                      dc_rd_req_i,
    input  wire [ADDR_WIDTH-1:0]     dc_rd_addr_i,
    output logic                     dc_rd_rdy_o,
    output logic                     dc_ret_valid_o,
    output logic [LINE_WIDTH-1:0]    dc_ret_data_o,
    // From the write engine
    input  wire                      wr_busy_i,
    // AR channel
    output bus_pkg::axi_id_t         ar_id_o,
    output logic [ADDR_WIDTH-1:0]    ar_addr_o,
    output logic                     ar_valid_o,
    input  wire                      ar_ready_i,
    // R channel
    input  wire bus_pkg::axi_id_t    r_id_i,
    input  wire [LINE_WIDTH-1:0]     r_data_i,
    input  wire                      r_valid_i,
    output logic                     r_ready_o
);

    bus_pkg::rd_state_e    state_q;
    bus_pkg::rd_state_e    state_d;
    logic [ADDR_WIDTH-1:0] addr_q;
    bus_pkg::axi_id_t      id_q;
    logic [LINE_WIDTH-1:0] ret_data_q;
    logic                  ic_ret_q;
    logic                  dc_ret_q;
    logic                  ic_acc;
    logic                  dc_acc;
    logic                  r_hs;

    // Data read must not pass a pending line write
    assign dc_rd_rdy_o = (state_q == bus_pkg::RD_IDLE) && !wr_busy_i;
    // Instruction side yields whenever the data side takes the slot
    assign ic_rd_rdy_o = (state_q == bus_pkg::RD_IDLE) && !(dc_rd_req_i && !wr_busy_i);

    assign dc_acc = dc_rd_req_i && dc_rd_rdy_o;
    assign ic_acc = ic_rd_req_i && ic_rd_rdy_o;
    assign r_hs   = r_valid_i && r_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            bus_pkg::RD_IDLE: begin
                if (dc_acc || ic_acc) begin
                    state_d = bus_pkg::RD_ADDR;
                end
            end
            bus_pkg::RD_ADDR: begin
                if (ar_ready_i) begin
                    state_d = bus_pkg::RD_DATA;
                end
            end
            bus_pkg::RD_DATA: begin
                if (r_valid_i) begin
                    state_d = bus_pkg::RD_IDLE;
                end
            end
            default: state_d = bus_pkg::RD_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q  <= bus_pkg::RD_IDLE;
            ic_ret_q <= 1'b0;
            dc_ret_q <= 1'b0;
        end else begin
            state_q  <= state_d;
            // Return pulse goes to whichever client owns the ID
            ic_ret_q <= r_hs && (r_id_i == bus_pkg::IC_ID);
            dc_ret_q <= r_hs && (r_id_i == bus_pkg::DC_ID);
        end
    end

    // Winner's request captured at acceptance
    always_ff @(posedge clk) begin
        if (dc_acc) begin
            addr_q <= dc_rd_addr_i;
            id_q   <= bus_pkg::DC_ID;
        end else if (ic_acc) begin
            addr_q <= ic_rd_addr_i;
            id_q   <= bus_pkg::IC_ID;
        end
        if (r_hs) begin
            ret_data_q <= r_data_i;
        end
    end

    assign ar_valid_o = (state_q == bus_pkg::RD_ADDR);
    assign ar_addr_o  = addr_q;
    assign ar_id_o    = id_q;
    assign r_ready_o  = (state_q == bus_pkg::RD_DATA);

    // One line register serves both clients, only the pulse is steered
    assign ic_ret_valid_o = ic_ret_q;
    assign dc_ret_valid_o = dc_ret_q;
    assign ic_ret_data_o  = ret_data_q;
    assign dc_ret_data_o  = ret_data_q;

    // Slave must answer with the ID that was issued
    a_rid_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        r_valid_i && r_ready_o |-> r_id_i == id_q);

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o));

    a_ret_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(ic_ret_valid_o && dc_ret_valid_o));

endmodule

`default_nettype wire

//--- source/write_channel.sv
`timescale 1ns/1ps
`default_nettype none

module write_channel #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_WIDTH = 128
) (
    input  wire                        clk,
    input  wire                        arst_n_i,
    // Data cache write port
    input  wire                        dc_wr_req_i,
    input  wire [ADDR_WIDTH-1:0]       dc_wr_addr_i,
    input  wire [LINE_WIDTH/8-1:0]     dc_wr_strb_i,
    input  wire [LINE_WIDTH-1:0]       dc_wr_data_i,
    output logic                       dc_wr_rdy_o,
    // To the read engine
    output logic                       wr_busy_o,
    // AW channel
    output bus_pkg::axi_id_t           aw_id_o,
    output logic [ADDR_WIDTH-1:0]      aw_addr_o,
    output logic                       aw_valid_o,
    input  wire                        aw_ready_i,
    // W channel
    output logic [LINE_WIDTH-1:0]      w_data_o,
    output logic [LINE_WIDTH/8-1:0]    w_strb_o,
    output logic                       w_valid_o,
    input  wire                        w_ready_i,
    // B channel
    input  wire bus_pkg::axi_id_t      b_id_i,
    input  wire                        b_valid_i,
    output logic                       b_ready_o
);

    localparam int STRB_WIDTH = LINE_WIDTH / 8;

    bus_pkg::wr_state_e    state_q;
    bus_pkg::wr_state_e    state_d;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic [LINE_WIDTH-1:0] data_q;
    logic [STRB_WIDTH-1:0] strb_q;
    logic                  aw_done_q;
    logic                  w_done_q;
    logic                  wr_acc;
    logic                  aw_hs;
    logic                  w_hs;

    assign dc_wr_rdy_o = (state_q == bus_pkg::WR_IDLE);
    assign wr_acc      = dc_wr_req_i && dc_wr_rdy_o;
    // Busy already in the acceptance cycle so a same-cycle read is held off
    assign wr_busy_o   = !dc_wr_rdy_o || dc_wr_req_i;

    assign aw_hs = aw_valid_o && aw_ready_i;
    assign w_hs  = w_valid_o && w_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            bus_pkg::WR_IDLE: begin
                if (wr_acc) begin
                    state_d = bus_pkg::WR_SEND;
                end
            end
            bus_pkg::WR_SEND: begin
                // AW and W may finish in either order
                if ((aw_done_q || aw_hs) && (w_done_q || w_hs)) begin
                    state_d = bus_pkg::WR_RESP;
                end
            end
            bus_pkg::WR_RESP: begin
                if (b_valid_i) begin
                    state_d = bus_pkg::WR_IDLE;
                end
            end
            default: state_d = bus_pkg::WR_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q   <= bus_pkg::WR_IDLE;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            if (wr_acc) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
            end else begin
                aw_done_q <= aw_done_q || aw_hs;
                w_done_q  <= w_done_q || w_hs;
            end
        end
    end

    // Client only holds the line in the accept cycle
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            addr_q <= dc_wr_addr_i;
            data_q <= dc_wr_data_i;
            strb_q <= dc_wr_strb_i;
        end
    end

    assign aw_id_o    = bus_pkg::DC_ID;
    assign aw_addr_o  = addr_q;
    assign aw_valid_o = (state_q == bus_pkg::WR_SEND) && !aw_done_q;
    assign w_data_o   = data_q;
    assign w_strb_o   = strb_q;
    assign w_valid_o  = (state_q == bus_pkg::WR_SEND) && !w_done_q;
    assign b_ready_o  = (state_q == bus_pkg::WR_RESP);

    // Only data cache writes exist, so every response carries its ID
    a_bid_match: assert property (@(posedge clk) disable iff (!arst_n_i)
        b_valid_i && b_ready_o |-> b_id_i == bus_pkg::DC_ID);

    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o));

endmodule

`default_nettype wire

//--- test/axi_slave_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_slave_model #(
    parameter int ADDR_WIDTH = 32,
    parameter int LINE_WIDTH = 128
) (
    input  wire                        clk,
    input  wire                        arst_n_i,
    input  wire bus_pkg::axi_id_t      ar_id_i,
    input  wire [ADDR_WIDTH-1:0]       ar_addr_i,
    input  wire                        ar_valid_i,
    output logic                       ar_ready_o,
    output bus_pkg::axi_id_t           r_id_o,
    output logic [LINE_WIDTH-1:0]      r_data_o,
    output logic                       r_valid_o,
    input  wire                        r_ready_i,
    input  wire bus_pkg::axi_id_t      aw_id_i,
    input  wire [ADDR_WIDTH-1:0]       aw_addr_i,
    input  wire                        aw_valid_i,
    output logic                       aw_ready_o,
    input  wire [LINE_WIDTH-1:0]       w_data_i,
    input  wire [LINE_WIDTH/8-1:0]     w_strb_i,
    input  wire                        w_valid_i,
    output logic                       w_ready_o,
    output bus_pkg::axi_id_t           b_id_o,
    output logic                       b_valid_o,
    input  wire                        b_ready_i,
    output logic                       stuck_o
);

    localparam int STALL_LIMIT = 100;

    logic [LINE_WIDTH-1:0] mem [16];
    logic                  rd_stuck;
    logic                  wr_stuck;

    assign stuck_o = rd_stuck || wr_stuck;

    // Every word of a line mixes in the line index
    function automatic logic [LINE_WIDTH-1:0] line_for_index(input int idx);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < LINE_WIDTH / 32; w++) begin
            line[w*32 +: 32] = 32'h9E37_79B9 * (idx * 4 + w + 1);
        end
        return line;
    endfunction

    // Outputs change 1 ns after the rising edge
    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Read side, one line per request
    initial begin
        logic [ADDR_WIDTH-1:0] addr;
        bus_pkg::axi_id_t      id;
        int                    n;
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_id_o     = '0;
        r_data_o   = '0;
        rd_stuck   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            mem[i] = line_for_index(i);
        end
        forever begin
            step_cycles(1);
            if (arst_n_i && ar_valid_i) begin
                step_cycles($urandom_range(3));
                ar_ready_o = 1'b1;
                addr       = ar_addr_i;
                id         = ar_id_i;
                step_cycles(1);
                ar_ready_o = 1'b0;
                step_cycles($urandom_range(3));
                r_id_o    = id;
                r_data_o  = mem[addr[7:4]];
                r_valid_o = 1'b1;
                n = 0;
                while (!r_ready_i && n < STALL_LIMIT) begin
                    step_cycles(1);
                    n++;
                end
                if (!r_ready_i) begin
                    rd_stuck = 1'b1;
                end
                step_cycles(1);
                r_valid_o = 1'b0;
            end
        end
    end

    // Write side, AW and W accepted independently
    initial begin
        logic [ADDR_WIDTH-1:0]   addr;
        logic [LINE_WIDTH-1:0]   data;
        logic [LINE_WIDTH/8-1:0] strb;
        bus_pkg::axi_id_t        id;
        int                      n;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_valid_o  = 1'b0;
        b_id_o     = '0;
        wr_stuck   = 1'b0;
        forever begin
            step_cycles(1);
            if (arst_n_i && aw_valid_i && w_valid_i) begin
                fork
                    begin
                        step_cycles($urandom_range(3));
                        aw_ready_o = 1'b1;
                        addr       = aw_addr_i;
                        id         = aw_id_i;
                        step_cycles(1);
                        aw_ready_o = 1'b0;
                    end
                    begin
                        step_cycles($urandom_range(3));
                        w_ready_o = 1'b1;
                        data      = w_data_i;
                        strb      = w_strb_i;
                        step_cycles(1);
                        w_ready_o = 1'b0;
                    end
                join
                for (int b = 0; b < LINE_WIDTH / 8; b++) begin
                    if (strb[b]) begin
                        mem[addr[7:4]][b*8 +: 8] = data[b*8 +: 8];
                    end
                end
                step_cycles($urandom_range(3));
                b_id_o    = id;
                b_valid_o = 1'b1;
                n = 0;
                while (!b_ready_i && n < STALL_LIMIT) begin
                    step_cycles(1);
                    n++;
                end
                if (!b_ready_i) begin
                    wr_stuck = 1'b1;
                end
                step_cycles(1);
                b_valid_o = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_mem_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_bridge;

    localparam int ADDR_WIDTH = 32;
    localparam int LINE_WIDTH = 128;
    localparam int STRB_WIDTH = LINE_WIDTH / 8;
    localparam int WAIT_LIMIT = 200;

    logic                    clk;
    logic                    arst_n_i;
    logic                    ic_rd_req_i;
    logic [ADDR_WIDTH-1:0]   ic_rd_addr_i;
    logic                    ic_rd_rdy_o;
    logic                    ic_ret_valid_o;
    logic [LINE_WIDTH-1:0]   ic_ret_data_o;
    logic                    dc_rd_req_i;
    logic [ADDR_WIDTH-1:0]   dc_rd_addr_i;
    logic                    dc_rd_rdy_o;
    logic                    dc_ret_valid_o;
    logic [LINE_WIDTH-1:0]   dc_ret_data_o;
    logic                    dc_wr_req_i;
    logic [ADDR_WIDTH-1:0]   dc_wr_addr_i;
    logic [STRB_WIDTH-1:0]   dc_wr_strb_i;
    logic [LINE_WIDTH-1:0]   dc_wr_data_i;
    logic                    dc_wr_rdy_o;
    bus_pkg::axi_id_t        ar_id_o;
    logic [ADDR_WIDTH-1:0]   ar_addr_o;
    logic                    ar_valid_o;
    logic                    ar_ready_i;
    bus_pkg::axi_id_t        r_id_i;
    logic [LINE_WIDTH-1:0]   r_data_i;
    logic                    r_valid_i;
    logic                    r_ready_o;
    bus_pkg::axi_id_t        aw_id_o;
    logic [ADDR_WIDTH-1:0]   aw_addr_o;
    logic                    aw_valid_o;
    logic                    aw_ready_i;
    logic [LINE_WIDTH-1:0]   w_data_o;
    logic [STRB_WIDTH-1:0]   w_strb_o;
    logic                    w_valid_o;
    logic                    w_ready_i;
    bus_pkg::axi_id_t        b_id_i;
    logic                    b_valid_i;
    logic                    b_ready_o;
    logic                    slave_stuck;

    // Shadow of the slave memory and the line each client expects
    logic [LINE_WIDTH-1:0]   shadow [16];
    logic [LINE_WIDTH-1:0]   ic_exp_line;
    logic [LINE_WIDTH-1:0]   dc_exp_line;
    logic                    ic_pending;
    logic                    dc_pending;

    mem_bridge_top #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) u_dut (.*);

    axi_slave_model #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .LINE_WIDTH (LINE_WIDTH)
    ) u_slave (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .ar_id_i    (ar_id_o),
        .ar_addr_i  (ar_addr_o),
        .ar_valid_i (ar_valid_o),
        .ar_ready_o (ar_ready_i),
        .r_id_o     (r_id_i),
        .r_data_o   (r_data_i),
        .r_valid_o  (r_valid_i),
        .r_ready_i  (r_ready_o),
        .aw_id_i    (aw_id_o),
        .aw_addr_i  (aw_addr_o),
        .aw_valid_i (aw_valid_o),
        .aw_ready_o (aw_ready_i),
        .w_data_i   (w_data_o),
        .w_strb_i   (w_strb_o),
        .w_valid_i  (w_valid_o),
        .w_ready_o  (w_ready_i),
        .b_id_o     (b_id_i),
        .b_valid_o  (b_valid_i),
        .b_ready_i  (b_ready_o),
        .stuck_o    (slave_stuck)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [LINE_WIDTH-1:0] line_for_index(input int idx);
        logic [LINE_WIDTH-1:0] line;
        for (int w = 0; w < LINE_WIDTH / 32; w++) begin
            line[w*32 +: 32] = 32'h9E37_79B9 * (idx * 4 + w + 1);
        end
        return line;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [LINE_WIDTH-1:0] expected,
                                   input logic [LINE_WIDTH-1:0] actual);
        abort_run($sformatf("CHECK FAILED %s expected %0h actual %0h", name, expected, actual));
    endtask

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic tick_guarded(input string what, inout int count);
        tick();
        count++;
        if (count > WAIT_LIMIT) begin
            abort_run($sformatf("Timed out waiting for %s", what));
        end
    endtask

    task automatic read_line(input bit use_dc, input logic [ADDR_WIDTH-1:0] addr);
        int n;
        n = 0;
        if (use_dc) begin
            dc_rd_req_i  = 1'b1;
            dc_rd_addr_i = addr;
        end else begin
            ic_rd_req_i  = 1'b1;
            ic_rd_addr_i = addr;
        end
        while (use_dc ? !dc_rd_rdy_o : !ic_rd_rdy_o) begin
            tick_guarded("read acceptance", n);
        end
        tick();
        dc_rd_req_i = 1'b0;
        ic_rd_req_i = 1'b0;
    endtask

    // Both read clients raise their request in the same cycle
    task automatic read_both(input logic [ADDR_WIDTH-1:0] ic_addr,
                             input logic [ADDR_WIDTH-1:0] dc_addr);
        int n;
        n = 0;
        ic_rd_req_i  = 1'b1;
        ic_rd_addr_i = ic_addr;
        dc_rd_req_i  = 1'b1;
        dc_rd_addr_i = dc_addr;
        while (!dc_rd_rdy_o) begin
            tick_guarded("data read acceptance", n);
        end
        tick();
        dc_rd_req_i = 1'b0;
        n = 0;
        while (!ic_rd_rdy_o) begin
            tick_guarded("instruction read acceptance", n);
        end
        tick();
        ic_rd_req_i = 1'b0;
    endtask

    task automatic write_line(input logic [ADDR_WIDTH-1:0] addr,
                              input logic [LINE_WIDTH-1:0] data,
                              input logic [STRB_WIDTH-1:0] strb);
        int n;
        n = 0;
        dc_wr_req_i  = 1'b1;
        dc_wr_addr_i = addr;
        dc_wr_data_i = data;
        dc_wr_strb_i = strb;
        while (!dc_wr_rdy_o) begin
            tick_guarded("write acceptance", n);
        end
        tick();
        dc_wr_req_i = 1'b0;
        // Bytewise merge into the shadow line
        for (int b = 0; b < STRB_WIDTH; b++) begin
            if (strb[b]) begin
                shadow[addr[7:4]][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (ic_pending || dc_pending || !dc_wr_rdy_o || !ic_rd_rdy_o) begin
            tick_guarded("the bridge to go idle", n);
        end
    endtask

    // Expected line is taken from the shadow at acceptance
    always @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ic_pending <= 1'b0;
            dc_pending <= 1'b0;
        end else begin
            if (ic_rd_req_i && ic_rd_rdy_o) begin
                ic_exp_line <= shadow[ic_rd_addr_i[7:4]];
                ic_pending  <= 1'b1;
            end else if (ic_ret_valid_o) begin
                ic_pending <= 1'b0;
            end
            if (dc_rd_req_i && dc_rd_rdy_o) begin
                dc_exp_line <= shadow[dc_rd_addr_i[7:4]];
                dc_pending  <= 1'b1;
            end else if (dc_ret_valid_o) begin
                dc_pending <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        if (slave_stuck) begin
            abort_run("Slave model never saw r_ready or b_ready from the bridge");
        end
    end

    a_ic_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        ic_ret_valid_o |-> ic_ret_data_o == ic_exp_line)
        else report_mismatch("ic_ret_data", $sampled(ic_exp_line), $sampled(ic_ret_data_o));

    a_dc_data: assert property (@(posedge clk) disable iff (!arst_n_i)
        dc_ret_valid_o |-> dc_ret_data_o == dc_exp_line)
        else report_mismatch("dc_ret_data", $sampled(dc_exp_line), $sampled(dc_ret_data_o));

    // A pulse without an accepted read means a stray or doubled return
    a_ic_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
        ic_ret_valid_o |-> ic_pending)
        else report_mismatch("ic_ret_owner", 1, 0);

    a_dc_owner: assert property (@(posedge clk) disable iff (!arst_n_i)
        dc_ret_valid_o |-> dc_pending)
        else report_mismatch("dc_ret_owner", 1, 0);

    a_dc_priority: assert property (@(posedge clk) disable iff (!arst_n_i)
        dc_rd_req_i && ic_rd_req_i && dc_rd_rdy_o |-> !ic_rd_rdy_o)
        else report_mismatch("rd_priority_ic_rdy", 0, 1);

    a_ar_id_dc: assert property (@(posedge clk) disable iff (!arst_n_i)
        dc_rd_req_i && dc_rd_rdy_o |=> ar_id_o == bus_pkg::DC_ID)
        else report_mismatch("ar_id_dc", bus_pkg::DC_ID, $sampled(ar_id_o));

    a_ar_id_ic: assert property (@(posedge clk) disable iff (!arst_n_i)
        ic_rd_req_i && ic_rd_rdy_o |=> ar_id_o == bus_pkg::IC_ID)
        else report_mismatch("ar_id_ic", bus_pkg::IC_ID, $sampled(ar_id_o));

    // Line writes come only from the data cache
    a_aw_id: assert property (@(posedge clk) disable iff (!arst_n_i)
        aw_valid_o |-> aw_id_o == bus_pkg::DC_ID)
        else report_mismatch("aw_id", bus_pkg::DC_ID, $sampled(aw_id_o));

    a_rd_behind_wr: assert property (@(posedge clk) disable iff (!arst_n_i)
        !dc_wr_rdy_o |-> !dc_rd_rdy_o)
        else report_mismatch("dc_rd_rdy_during_write", 0, 1);

    a_ar_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_addr_o) && $stable(ar_id_o))
        else report_mismatch("ar_hold", 1, 0);

    a_aw_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_addr_o))
        else report_mismatch("aw_hold", 1, 0);

    a_w_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_data_o) && $stable(w_strb_o))
        else report_mismatch("w_hold", 1, 0);

    initial begin
        logic [3:0]            idx;
        logic [ADDR_WIDTH-1:0] addr;
        logic [LINE_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        void'($urandom(72526));
        arst_n_i     = 1'b0;
        ic_rd_req_i  = 1'b0;
        ic_rd_addr_i = '0;
        dc_rd_req_i  = 1'b0;
        dc_rd_addr_i = '0;
        dc_wr_req_i  = 1'b0;
        dc_wr_addr_i = '0;
        dc_wr_strb_i = '0;
        dc_wr_data_i = '0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = line_for_index(i);
        end
        repeat (5) @(posedge clk);
        #1;
        arst_n_i = 1'b1;
        tick();

        read_line(1'b0, 32'h8000_0030);
        wait_idle();
        read_both(32'h8000_0050, 32'h8000_0070);
        wait_idle();

        // Write then read back, with an instruction read in between
        for (int t = 0; t < 12; t++) begin
            idx  = 4'($urandom_range(15));
            addr = 32'h8000_0000 | {24'h0, idx, 4'h0};
            data = {$urandom, $urandom, $urandom, $urandom};
            strb = STRB_WIDTH'($urandom);
            write_line(addr, data, strb);
            read_line(1'b1, addr);
            wait_idle();
            idx = 4'($urandom_range(15));
            read_line(1'b0, 32'h8000_0000 | {24'h0, idx, 4'h0});
            wait_idle();
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire
